//--- build.f
source/axi_pkg.sv
source/remap_pkg.sv
source/remap_slot_if.sv
source/id_remap_slot.sv
source/ar_slot_alloc.sv
source/r_id_restore.sv
source/axi_iw_converter.sv
tests/axi_iw_converter_asserts.sv
tests/tb_axi_iw_converter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the converter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
  --top-module tb_axi_iw_converter -Mdir obj_dir -o sim_tb

output="$(./obj_dir/sim_tb)" || true
echo "$output"

if echo "$output" | grep -Fqx "=== PASS ==="; then
  exit 0
fi
exit 1

//--- source/ar_slot_alloc.sv
`timescale 1ns/100ps

// AR side of the remapper
// Picks a slot for the incoming ID and puts the slot index out as the narrow ID
module ar_slot_alloc
  import axi_pkg::*;
  import remap_pkg::*;
#(
  parameter int unsigned TableSize  = 4,
  parameter int unsigned SlvIdWidth = 6
) (
  // Slave side AR
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  input  logic [SlvIdWidth-1:0] slv_ar_id_i,
  input  addr_t                 slv_ar_addr_i,
  input  len_t                  slv_ar_len_i,
  // Master side AR
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  output logic [(TableSize > 1 ? $clog2(TableSize) : 1)-1:0] mst_ar_id_o,
  output addr_t                 mst_ar_addr_o,
  output len_t                  mst_ar_len_o,
  // One interface per table slot
  remap_slot_if.alloc_mp        slots [TableSize]
);

  localparam int unsigned MstIdWidth = (TableSize > 1) ? $clog2(TableSize) : 1;

  // Slot status flattened for the search loops
  logic [TableSize-1:0]  busy;
  logic [TableSize-1:0]  full;
  logic [TableSize-1:0]  hit;

  logic                  hit_found;
  logic [MstIdWidth-1:0] hit_idx;
  logic                  free_found;
  logic [MstIdWidth-1:0] free_idx;

  ar_decision_e          decision;
  logic [MstIdWidth-1:0] sel_idx;
  logic                  ar_hs;

  for (genvar i = 0; i < TableSize; i++) begin : gen_slot
    assign busy[i] = slots[i].busy;
    assign full[i] = slots[i].full;
    // Only a busy slot holds a valid ID
    assign hit[i]  = slots[i].busy && (slots[i].slot_id == slv_ar_id_i);

    // Alloc fires only for the chosen slot, and only on the handshake
    assign slots[i].alloc    = ar_hs && (sel_idx == MstIdWidth'(i));
    assign slots[i].alloc_id = slv_ar_id_i;
  end

  // Search from the top down so the lowest index wins
  // At most one slot can match, since a live ID is always reused
  always_comb begin
    hit_found  = 1'b0;
    hit_idx    = '0;
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (hit[i]) begin
        hit_found = 1'b1;
        hit_idx   = MstIdWidth'(i);
      end
      if (!busy[i]) begin
        free_found = 1'b1;
        free_idx   = MstIdWidth'(i);
      end
    end
  end

  // Allocation verdict
  // A matching slot that is full blocks the AR even if others are free
  always_comb begin
    if (hit_found) begin
      decision = full[hit_idx] ? AR_STALL : AR_REUSE;
      sel_idx  = hit_idx;
    end else if (free_found) begin
      decision = AR_ALLOC;
      sel_idx  = free_idx;
    end else begin
      decision = AR_STALL;
      sel_idx  = '0;
    end
  end

  // Valid and ready both gated by the verdict, valid never looks at ready
  assign mst_ar_valid_o = slv_ar_valid_i && (decision != AR_STALL);
  assign slv_ar_ready_o = mst_ar_ready_i && (decision != AR_STALL);
  assign ar_hs          = mst_ar_valid_o && mst_ar_ready_i;

  // Slot index becomes the narrow ID, rest of the beat is untouched
  assign mst_ar_id_o   = sel_idx;
  assign mst_ar_addr_o = slv_ar_addr_i;
  assign mst_ar_len_o  = slv_ar_len_i;

endmodule

//--- source/axi_iw_converter.sv
`timescale 1ns/100ps

// AXI4 read path ID width converter, wide slave ID down to narrow master ID
// Allocator, slot table and restorer around one shared array of slot interfaces
module axi_iw_converter
  import axi_pkg::*;
  import remap_pkg::*;
#(
  parameter int unsigned TableSize    = DefaultTableSize,
  parameter int unsigned SlvIdWidth   = DefaultSlvIdWidth,
  parameter int unsigned MaxTxnsPerId = DefaultMaxTxnsPerId
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Slave port AR
  input  logic                  slv_ar_valid_i,
  output logic                  slv_ar_ready_o,
  input  logic [SlvIdWidth-1:0] slv_ar_id_i,
  input  addr_t                 slv_ar_addr_i,
  input  len_t                  slv_ar_len_i,
  // Slave port R
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,
  output logic [SlvIdWidth-1:0] slv_r_id_o,
  output data_t                 slv_r_data_o,
  output resp_e                 slv_r_resp_o,
  output logic                  slv_r_last_o,
  // Master port AR
  output logic                  mst_ar_valid_o,
  input  logic                  mst_ar_ready_i,
  output logic [(TableSize > 1 ? $clog2(TableSize) : 1)-1:0] mst_ar_id_o,
  output addr_t                 mst_ar_addr_o,
  output len_t                  mst_ar_len_o,
  // Master port R
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o,
  input  logic [(TableSize > 1 ? $clog2(TableSize) : 1)-1:0] mst_r_id_i,
  input  data_t                 mst_r_data_i,
  input  resp_e                 mst_r_resp_i,
  input  logic                  mst_r_last_i
);

  // One bundle per slot, shared by all three blocks
  remap_slot_if #(.SlvIdWidth(SlvIdWidth)) slot_if [TableSize] ();

  // AR path: slot match or allocation, ID rewrite
  ar_slot_alloc #(
    .TableSize  ( TableSize  ),
    .SlvIdWidth ( SlvIdWidth )
  ) i_ar_slot_alloc (
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_ar_id_i    ( slv_ar_id_i    ),
    .slv_ar_addr_i  ( slv_ar_addr_i  ),
    .slv_ar_len_i   ( slv_ar_len_i   ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_id_o    ( mst_ar_id_o    ),
    .mst_ar_addr_o  ( mst_ar_addr_o  ),
    .mst_ar_len_o   ( mst_ar_len_o   ),
    .slots          ( slot_if        )
  );

  // Remap table, the only state in the design
  for (genvar i = 0; i < TableSize; i++) begin : gen_slot
    id_remap_slot #(
      .SlvIdWidth   ( SlvIdWidth   ),
      .MaxTxnsPerId ( MaxTxnsPerId )
    ) i_slot (
      .clk_i    ( clk_i      ),
      .arst_n_i ( arst_n_i   ),
      .slot     ( slot_if[i] )
    );
  end

  // R path: wide ID restore and burst release
  r_id_restore #(
    .TableSize  ( TableSize  ),
    .SlvIdWidth ( SlvIdWidth )
  ) i_r_id_restore (
    .mst_r_valid_i ( mst_r_valid_i ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .mst_r_id_i    ( mst_r_id_i    ),
    .mst_r_data_i  ( mst_r_data_i  ),
    .mst_r_resp_i  ( mst_r_resp_i  ),
    .mst_r_last_i  ( mst_r_last_i  ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .slv_r_id_o    ( slv_r_id_o    ),
    .slv_r_data_o  ( slv_r_data_o  ),
    .slv_r_resp_o  ( slv_r_resp_o  ),
    .slv_r_last_o  ( slv_r_last_o  ),
    .slots         ( slot_if       )
  );

endmodule

//--- source/axi_pkg.sv
// AXI4 read channel field types shared by the converter and its testbench
package axi_pkg;

  // Address and data widths are fixed for this read path
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;

  typedef logic [AxiAddrWidth-1:0] addr_t;
  typedef logic [AxiDataWidth-1:0] data_t;

  // Burst length, beats minus one
  typedef logic [7:0] len_t;

  // Read response code as carried on RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

//--- source/id_remap_slot.sv
`timescale 1ns/100ps

// Single remap table entry
// Holds one slave ID and counts its bursts still in flight
module id_remap_slot #(
  parameter int unsigned SlvIdWidth   = 6,
  parameter int unsigned MaxTxnsPerId = 3
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  remap_slot_if.slot_mp        slot
);

  // Counter must hold 0 up to MaxTxnsPerId
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  logic [CntWidth-1:0]   cnt_q;
  logic [SlvIdWidth-1:0] id_q;

  // Outstanding burst count
  // An alloc and a release in the same cycle cancel out
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (slot.alloc && !slot.dealloc) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (slot.dealloc && !slot.alloc) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Stored ID is only taken by a fresh allocation
  // A reuse leaves it alone since it already matches
  always_ff @(posedge clk_i) begin
    if (slot.alloc && !slot.busy) begin
      id_q <= slot.alloc_id;
    end
  end

  // Status back to allocator and restorer
  assign slot.busy    = (cnt_q != '0);
  assign slot.full    = (cnt_q == CntWidth'(MaxTxnsPerId));
  assign slot.slot_id = id_q;

endmodule

//--- source/r_id_restore.sv
`timescale 1ns/100ps

// R side of the remapper
// Puts the wide ID back on each beat and frees the burst on its last beat
module r_id_restore
  import axi_pkg::*;
#(
  parameter int unsigned TableSize  = 4,
  parameter int unsigned SlvIdWidth = 6
) (
  // Master side R
  input  logic                  mst_r_valid_i,
  output logic                  mst_r_ready_o,
  input  logic [(TableSize > 1 ? $clog2(TableSize) : 1)-1:0] mst_r_id_i,
  input  data_t                 mst_r_data_i,
  input  resp_e                 mst_r_resp_i,
  input  logic                  mst_r_last_i,
  // Slave side R
  output logic                  slv_r_valid_o,
  input  logic                  slv_r_ready_i,
  output logic [SlvIdWidth-1:0] slv_r_id_o,
  output data_t                 slv_r_data_o,
  output resp_e                 slv_r_resp_o,
  output logic                  slv_r_last_o,
  // One interface per table slot
  remap_slot_if.drain_mp        slots [TableSize]
);

  localparam int unsigned MstIdWidth = (TableSize > 1) ? $clog2(TableSize) : 1;

  logic [SlvIdWidth-1:0] slot_ids [TableSize];
  logic                  last_hs;

  // Accepted last beat ends one burst of the slot named by the R ID
  assign last_hs = mst_r_valid_i && slv_r_ready_i && mst_r_last_i;

  for (genvar i = 0; i < TableSize; i++) begin : gen_slot
    assign slot_ids[i]     = slots[i].slot_id;
    assign slots[i].dealloc = last_hs && (mst_r_id_i == MstIdWidth'(i));
  end

  // Narrow ID is the slot index, so a plain lookup gives the wide ID back
  assign slv_r_id_o    = slot_ids[mst_r_id_i];

  // Everything else goes straight through
  assign slv_r_valid_o = mst_r_valid_i;
  assign slv_r_data_o  = mst_r_data_i;
  assign slv_r_resp_o  = mst_r_resp_i;
  assign slv_r_last_o  = mst_r_last_i;
  assign mst_r_ready_o = slv_r_ready_i;

endmodule

//--- source/remap_pkg.sv
// Definitions for the ID remap table
package remap_pkg;

  // Verdict of the allocator for the AR at its input
  typedef enum logic [1:0] {
    // ID already has a slot with room left
    AR_REUSE = 2'b00,
    // New ID takes the lowest free slot
    AR_ALLOC = 2'b01,
    // No slot can take this AR now
    AR_STALL = 2'b10
  } ar_decision_e;

  // Defaults for the top level parameters
  localparam int unsigned DefaultTableSize    = 4;
  localparam int unsigned DefaultSlvIdWidth   = 6;
  localparam int unsigned DefaultMaxTxnsPerId = 3;

endpackage

//--- source/remap_slot_if.sv
`timescale 1ns/100ps

// One remap table entry as seen by the allocator, the slot and the restorer
interface remap_slot_if #(
  parameter int unsigned SlvIdWidth = 6
);

  // Allocation pulse and the ID to store on it
  logic                  alloc;
  logic [SlvIdWidth-1:0] alloc_id;
  // Release pulse on the last R beat of a burst
  logic                  dealloc;
  // Slot status
  logic                  busy;
  logic                  full;
  logic [SlvIdWidth-1:0] slot_id;

  // Allocator side
  modport alloc_mp (output alloc, alloc_id, input busy, full, slot_id);

  // The slot itself
  modport slot_mp (input alloc, alloc_id, dealloc, output busy, full, slot_id);

  // Response side, restores IDs and frees bursts
  modport drain_mp (output dealloc, input slot_id);

endinterface

//--- tests/axi_iw_converter_asserts.sv
`timescale 1ns/100ps

// Port level checks on the converter, bound into every instance
module axi_iw_converter_asserts
  import axi_pkg::*;
(
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  slv_ar_valid_i,
  input addr_t slv_ar_addr_i,
  input len_t  slv_ar_len_i,
  input logic  mst_ar_valid_i,
  input addr_t mst_ar_addr_i,
  input len_t  mst_ar_len_i,
  input logic  slv_r_valid_i
);

  // Address and length pass through untouched
  ar_fields_pass: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mst_ar_valid_i |-> (mst_ar_addr_i == slv_ar_addr_i) && (mst_ar_len_i == slv_ar_len_i)
  ) else $error("Master AR address or length differs from the slave AR");

  // Nothing valid leaves while reset is held
  quiet_in_reset: assert property (
    @(posedge clk_i)
    !arst_n_i |-> !mst_ar_valid_i && !slv_r_valid_i
  ) else $error("Valid driven out of the converter during reset");

  // Master AR only ever follows a slave AR
  ar_valid_follows: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $rose(mst_ar_valid_i) |-> slv_ar_valid_i
  ) else $error("Master AR valid rose with no slave AR valid");

endmodule

bind axi_iw_converter axi_iw_converter_asserts i_asserts (
  .clk_i          ( clk_i          ),
  .arst_n_i       ( arst_n_i       ),
  .slv_ar_valid_i ( slv_ar_valid_i ),
  .slv_ar_addr_i  ( slv_ar_addr_i  ),
  .slv_ar_len_i   ( slv_ar_len_i   ),
  .mst_ar_valid_i ( mst_ar_valid_o ),
  .mst_ar_addr_i  ( mst_ar_addr_o  ),
  .mst_ar_len_i   ( mst_ar_len_o   ),
  .slv_r_valid_i  ( slv_r_valid_o  )
);

//--- tests/tb_axi_iw_converter.sv
`timescale 1ns/100ps

// Testbench for the AXI4 read path ID width converter
module tb_axi_iw_converter
  import axi_pkg::*;
  import remap_pkg::*;
();

  localparam int unsigned TableSize = DefaultTableSize;
  localparam int unsigned MaxTxns   = DefaultMaxTxnsPerId;
  localparam int unsigned NumRandom = 150;
  // About 200 bursts in all, none needs more than 20 cycles
  localparam int unsigned MaxCycles = 4000;

  typedef logic [$clog2(DefaultTableSize)-1:0] idx_t;
  typedef logic [DefaultSlvIdWidth-1:0] sid_t;

  logic  clk_i;
  logic  arst_n_i;
  logic  slv_ar_valid_i, slv_ar_ready_o;
  sid_t  slv_ar_id_i;
  addr_t slv_ar_addr_i;
  len_t  slv_ar_len_i;
  logic  slv_r_valid_o, slv_r_ready_i, slv_r_last_o;
  sid_t  slv_r_id_o;
  data_t slv_r_data_o;
  resp_e slv_r_resp_o;
  logic  mst_ar_valid_o, mst_ar_ready_i;
  idx_t  mst_ar_id_o;
  addr_t mst_ar_addr_o;
  len_t  mst_ar_len_o;
  logic  mst_r_valid_i, mst_r_ready_o, mst_r_last_i;
  idx_t  mst_r_id_i;
  data_t mst_r_data_i;
  resp_e mst_r_resp_i;

  // Reference slot table, filled at master AR and emptied on last R beats
  sid_t  model_id [TableSize] = '{default: '0};
  int    model_cnt [TableSize] = '{default: 0};
  len_t  pend_len [TableSize][$];
  // Bursts of each slot already started by the responder
  int    served [TableSize] = '{default: 0};
  int    beats_left;
  // Master ID the converter put on the latest accepted AR
  int    last_idx;
  bit    r_hold;
  int    errors;
  int    errors_seen;
  int    tests_run;
  int    tests_failed;

  axi_iw_converter UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Ends a run that hangs
  initial begin : watchdog
    for (int c = 0; c < MaxCycles; c++) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic flag_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Slot the converter has to pick for the AR at its input, -1 when none is free
  always @(posedge clk_i) begin : monitor
    int exp_idx;
    bit stall;
    if (arst_n_i) begin
      exp_idx = -1;
      for (int s = TableSize - 1; s >= 0; s--) begin
        if (model_cnt[idx_t'(s)] == 0) exp_idx = s;
      end
      // A live slot with the same ID always wins
      for (int s = 0; s < TableSize; s++) begin
        if (model_cnt[idx_t'(s)] != 0 && model_id[idx_t'(s)] == slv_ar_id_i) exp_idx = s;
      end
      stall = (exp_idx < 0) ? 1'b1 : (model_cnt[idx_t'(exp_idx)] == MaxTxns);
      if (slv_ar_valid_i) begin
        assert (mst_ar_valid_o == !stall && slv_ar_ready_o == (!stall && mst_ar_ready_i))
          else flag_mismatch($sformatf("AR valid %b ready %b, stall expected %b",
                                       mst_ar_valid_o, slv_ar_ready_o, stall));
      end
      // Handshake as the AXI rules predict it
      if (slv_ar_valid_i && mst_ar_ready_i && !stall) begin
        assert (int'(mst_ar_id_o) == exp_idx)
          else flag_mismatch($sformatf("AR ID %0d, expected %0d", mst_ar_id_o, exp_idx));
        if (model_cnt[idx_t'(exp_idx)] == 0) model_id[idx_t'(exp_idx)] = slv_ar_id_i;
        model_cnt[idx_t'(exp_idx)]++;
        pend_len[idx_t'(exp_idx)].push_back(slv_ar_len_i);
        last_idx = int'(mst_ar_id_o);
      end
      if (mst_r_valid_i && slv_r_ready_i) begin
        assert (slv_r_valid_o && slv_r_id_o == model_id[mst_r_id_i])
          else flag_mismatch($sformatf("R ID %0h, expected %0h",
                                       slv_r_id_o, model_id[mst_r_id_i]));
        assert (slv_r_data_o == mst_r_data_i && slv_r_resp_o == mst_r_resp_i &&
                slv_r_last_o == mst_r_last_i && mst_r_ready_o)
          else flag_mismatch("R data, resp, last or ready not passed through");
        if (mst_r_last_i) model_cnt[mst_r_id_i]--;
      end
    end
  end

  // Memory on the master port, one burst at a time
  initial begin : responder
    int   start;
    idx_t sel;
    bit   found;
    mst_ar_ready_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_r_valid_i  = 1'b0;
    mst_r_id_i     = '0;
    mst_r_data_i   = '0;
    mst_r_resp_i   = OKAY;
    mst_r_last_i   = 1'b0;
    beats_left     = 0;
    forever begin
      @(negedge clk_i);
      if (arst_n_i) begin
        // Beat held over the last rising edge was taken if ready was high
        if (mst_r_valid_i && mst_r_ready_o) begin
          beats_left--;
          mst_r_valid_i = (beats_left != 0);
          mst_r_last_i  = (beats_left == 1);
          mst_r_data_i  = $urandom;
          mst_r_resp_i  = resp_e'($urandom_range(3, 0));
        end
        // Random order across slots, in order within a slot
        if (!mst_r_valid_i && !r_hold) begin
          start = $urandom_range(TableSize - 1, 0);
          found = 1'b0;
          for (int k = 0; k < TableSize; k++) begin
            if (!found && pend_len[idx_t'(start + k)].size() > served[idx_t'(start + k)]) begin
              found = 1'b1;
              sel   = idx_t'(start + k);
            end
          end
          if (found) begin
            beats_left = int'(pend_len[sel][served[sel]]) + 1;
            served[sel]++;
            mst_r_id_i    = sel;
            mst_r_valid_i = 1'b1;
            mst_r_last_i  = (beats_left == 1);
            mst_r_data_i  = $urandom;
            mst_r_resp_i  = resp_e'($urandom_range(3, 0));
          end
        end
        mst_ar_ready_i = ($urandom_range(3, 0) != 0);
        slv_r_ready_i  = ($urandom_range(3, 0) != 0);
      end
    end
  end

  task automatic drive_ar(input sid_t id, input len_t len);
    @(negedge clk_i);
    slv_ar_valid_i = 1'b1;
    slv_ar_id_i    = id;
    slv_ar_addr_i  = $urandom;
    slv_ar_len_i   = len;
  endtask

  // Holds the AR until the handshake, then drops valid
  task automatic wait_ar_accept();
    @(posedge clk_i);
    while (!slv_ar_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    slv_ar_valid_i = 1'b0;
  endtask

  task automatic send_ar(input sid_t id, input len_t len);
    drive_ar(id, len);
    wait_ar_accept();
  endtask

  function automatic int outstanding();
    int total;
    total = 0;
    for (int s = 0; s < TableSize; s++) total += model_cnt[idx_t'(s)];
    return total;
  endfunction

  task automatic finish_test(input string name);
    @(negedge clk_i);
    while (outstanding() != 0) @(negedge clk_i);
    tests_run++;
    if (errors != errors_seen) tests_failed++;
    $display("Test %-16s %s", name, (errors == errors_seen) ? "passed" : "failed");
    errors_seen = errors;
  endtask

  initial begin : main
    int first_idx;
    void'($urandom(32'h735dbaa4));
    arst_n_i       = 1'b0;
    slv_ar_valid_i = 1'b0;
    slv_ar_id_i    = '0;
    slv_ar_addr_i  = '0;
    slv_ar_len_i   = '0;
    r_hold         = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // Two IDs interleaved, repeats land on their first slot
    send_ar(6'h05, 8'd1);
    send_ar(6'h2a, 8'd0);
    send_ar(6'h05, 8'd3);
    send_ar(6'h2a, 8'd2);
    finish_test("reuse_and_alloc");

    // Every slot taken, a fresh ID waits for a drain
    r_hold = 1'b1;
    for (int i = 0; i < TableSize; i++) send_ar(sid_t'(8 + i), 8'd1);
    drive_ar(6'h30, 8'd0);
    repeat (20) @(posedge clk_i);
    r_hold = 1'b0;
    wait_ar_accept();
    finish_test("table_full");

    // One ID at its burst limit
    r_hold = 1'b1;
    repeat (MaxTxns) send_ar(6'h11, 8'd2);
    first_idx = last_idx;
    drive_ar(6'h11, 8'd0);
    repeat (20) @(posedge clk_i);
    r_hold = 1'b0;
    wait_ar_accept();
    assert (last_idx == first_idx)
      else flag_mismatch($sformatf("ID at limit went to slot %0d, not %0d", last_idx, first_idx));
    finish_test("per_id_limit");

    // Drained slot 0 is claimed again by a new ID
    send_ar(6'h21, 8'd0);
    send_ar(6'h22, 8'd0);
    finish_test("release_prep");
    send_ar(6'h23, 8'd1);
    assert (last_idx == 0)
      else flag_mismatch($sformatf("New ID took slot %0d, expected 0", last_idx));
    finish_test("release_on_last");

    // Eight IDs over four slots, so stalls of both kinds happen
    for (int i = 0; i < NumRandom; i++) begin
      send_ar(sid_t'(8 * $urandom_range(7, 0) + 3), 8'($urandom_range(3, 0)));
    end
    finish_test("random_traffic");

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
